//--- common/rv_pkg.sv
package rv_pkg;

    parameter int xlen = 32;
    parameter int reg_addr_w = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // base opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    typedef enum logic [1:0] {
        fwd_reg = 2'd0,
        fwd_mem = 2'd1,
        fwd_wb  = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    // one instruction word, four views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_u;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        word_t    rd1;
        word_t    rd2;
        word_t    imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_read;
        word_t    alu_result;
        reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

//--- rtl/fetch_stage.sv
module fetch_stage #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall_f,
    input  logic           stall_d,
    input  logic           flush_d,
    input  logic           branch_taken,
    input  rv_pkg::word_t  branch_target,
    input  rv_pkg::word_t  instr,
    output rv_pkg::word_t  pc,
    output rv_pkg::if_id_t if_id
);
    import rv_pkg::*;

    word_t pc_next;

    // redirect wins over the load-use hold
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else if (stall_f) begin
            pc_next = pc;
        end else begin
            pc_next = pc + word_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // fetch/decode register, only valid is cleared
    always_ff @(posedge clk) begin
        if (rst || flush_d) begin
            if_id.valid <= 1'b0;
        end else if (!stall_d) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= instr;
        end
    end

endmodule

//--- decode/reg_file.sv
module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t ra1,
    input  rv_pkg::reg_idx_t ra2,
    output rv_pkg::word_t    rd1,
    output rv_pkg::word_t    rd2,
    input  rv_pkg::wb_t      wb
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:2**reg_addr_w-1];

    function automatic word_t read_port(input reg_idx_t ra, input wb_t w, input word_t stored);
        if (ra == '0) begin
            return '0;
        end else if (w.we && w.rd == ra) begin
            return w.data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rd1 = read_port(ra1, wb, regs[ra1]);
    assign rd2 = read_port(ra2, wb, regs[ra2]);

endmodule

//--- decode/decode_stage.sv
module decode_stage (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::if_id_t   if_id,
    input  logic             flush_e,
    input  rv_pkg::wb_t      wb,
    output rv_pkg::id_ex_t   id_ex,
    output rv_pkg::reg_idx_t rs1_d,
    output rv_pkg::reg_idx_t rs2_d
);
    import rv_pkg::*;

    instr_u ins;
    ctrl_t  ctrl_d;
    word_t  imm_d;
    word_t  rd1;
    word_t  rd2;
    logic   uses_rs2;

    assign ins = if_id.instr;

    always_comb begin
        ctrl_d   = '0;
        imm_d    = '0;
        uses_rs2 = 1'b0;
        case (ins.r.opcode)
            opc_op: begin
                uses_rs2         = 1'b1;
                ctrl_d.reg_write = 1'b1;
                case (ins.r.funct3)
                    3'b000:  ctrl_d.alu_op = ins.r.funct7[5] ? alu_sub : alu_add;
                    3'b111:  ctrl_d.alu_op = alu_and;
                    3'b110:  ctrl_d.alu_op = alu_or;
                    3'b100:  ctrl_d.alu_op = alu_xor;
                    3'b010:  ctrl_d.alu_op = alu_slt;
                    default: ctrl_d.reg_write = 1'b0;
                endcase
            end
            opc_op_imm: begin
                // only ADDI
                ctrl_d.reg_write = (ins.i.funct3 == 3'b000);
                ctrl_d.alu_src   = 1'b1;
                imm_d = {{(xlen-12){ins.i.imm[11]}}, ins.i.imm};
            end
            opc_load: begin
                ctrl_d.reg_write = 1'b1;
                ctrl_d.mem_read  = 1'b1;
                ctrl_d.alu_src   = 1'b1;
                imm_d = {{(xlen-12){ins.i.imm[11]}}, ins.i.imm};
            end
            opc_store: begin
                uses_rs2         = 1'b1;
                ctrl_d.mem_write = 1'b1;
                ctrl_d.alu_src   = 1'b1;
                imm_d = {{(xlen-12){ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
            end
            opc_branch: begin
                uses_rs2      = 1'b1;
                ctrl_d.branch = 1'b1;
                imm_d = {{(xlen-13){ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
                         ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
            end
            default: ctrl_d = '0;
        endcase
        if (!if_id.valid) begin
            ctrl_d = '0;
        end
    end

    assign rs1_d = ins.r.rs1;
    assign rs2_d = uses_rs2 ? ins.r.rs2 : '0;

    reg_file u_reg_file (
        .clk(clk),
        .rst(rst),
        .ra1(rs1_d),
        .ra2(rs2_d),
        .rd1(rd1),
        .rd2(rd2),
        .wb(wb)
    );

    // bubble on flush
    always_ff @(posedge clk) begin
        if (rst || flush_e) begin
            id_ex.ctrl <= '0;
        end else begin
            id_ex.ctrl <= ctrl_d;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.pc  <= if_id.pc;
        id_ex.rd1 <= rd1;
        id_ex.rd2 <= rd2;
        id_ex.imm <= imm_d;
        id_ex.rs1 <= rs1_d;
        id_ex.rs2 <= rs2_d;
        id_ex.rd  <= ins.r.rd;
    end

endmodule

//--- rtl/execute_stage.sv
module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::fwd_sel_e  fwd_a,
    input  rv_pkg::fwd_sel_e  fwd_b,
    output rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::wb_t       wb,
    output rv_pkg::word_t     data_addr,
    output rv_pkg::word_t     din,
    output logic              data_we,
    output logic              data_re,
    output logic              branch_taken,
    output rv_pkg::word_t     branch_target
);
    import rv_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t src_b;
    word_t alu_result;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_a, id_ex.rd1, ex_mem.alu_result, wb.data);
    assign op_b  = fwd_mux(fwd_b, id_ex.rd2, ex_mem.alu_result, wb.data);
    assign src_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_sub: alu_result = op_a - src_b;
            alu_and: alu_result = op_a & src_b;
            alu_or:  alu_result = op_a | src_b;
            alu_xor: alu_result = op_a ^ src_b;
            alu_slt: alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(src_b)};
            default: alu_result = op_a + src_b;
        endcase
    end

    // BEQ resolves here
    assign branch_taken  = id_ex.ctrl.branch && (op_a == op_b);
    assign branch_target = id_ex.pc + id_ex.imm;

    // request goes out now so read data lands in the memory stage
    assign data_addr = alu_result;
    assign din       = op_b;
    assign data_we   = id_ex.ctrl.mem_write;
    assign data_re   = id_ex.ctrl.mem_read;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
        end else begin
            ex_mem.reg_write <= id_ex.ctrl.reg_write;
            ex_mem.mem_read  <= id_ex.ctrl.mem_read;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.alu_result <= alu_result;
        ex_mem.rd         <= id_ex.rd;
    end

endmodule

//--- rtl/hazard_unit.sv
module hazard_unit (
    input  rv_pkg::reg_idx_t rs1_d,
    input  rv_pkg::reg_idx_t rs2_d,
    input  rv_pkg::id_ex_t   id_ex,
    input  rv_pkg::ex_mem_t  ex_mem,
    input  rv_pkg::wb_t      wb,
    input  logic             branch_taken,
    output logic             stall_f,
    output logic             stall_d,
    output logic             flush_d,
    output logic             flush_e,
    output rv_pkg::fwd_sel_e fwd_a,
    output rv_pkg::fwd_sel_e fwd_b
);
    import rv_pkg::*;

    logic lw_stall;

    // youngest producer first
    function automatic fwd_sel_e fwd_for(input reg_idx_t rs, input ex_mem_t m, input wb_t w);
        if (m.reg_write && m.rd != '0 && m.rd == rs) begin
            return fwd_mem;
        end else if (w.we && w.rd != '0 && w.rd == rs) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    assign fwd_a = fwd_for(id_ex.rs1, ex_mem, wb);
    assign fwd_b = fwd_for(id_ex.rs2, ex_mem, wb);

    // load in execute feeding decode
    assign lw_stall = id_ex.ctrl.mem_read && id_ex.rd != '0
                   && (id_ex.rd == rs1_d || id_ex.rd == rs2_d);

    assign stall_f = lw_stall && !branch_taken;
    assign stall_d = lw_stall && !branch_taken;
    assign flush_d = branch_taken;
    assign flush_e = branch_taken || lw_stall;

endmodule

//--- rtl/mem_wb_stage.sv
module mem_wb_stage (
    input  logic            clk,
    input  logic            rst,
    input  rv_pkg::ex_mem_t ex_mem,
    input  rv_pkg::word_t   read_data,
    output rv_pkg::wb_t     wb
);
    import rv_pkg::*;

    word_t result_m;

    // read_data is only valid while the load sits in memory
    assign result_m = ex_mem.mem_read ? read_data : ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.we <= 1'b0;
        end else begin
            wb.we <= ex_mem.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd   <= ex_mem.rd;
        wb.data <= result_m;
    end

endmodule

//--- rtl/riscv_pipeline.sv
module riscv_pipeline #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  logic          clk,
    input  logic          rst,
    output rv_pkg::word_t pc,
    input  rv_pkg::word_t instr,
    output rv_pkg::word_t data_addr,
    output rv_pkg::word_t din,
    output logic          data_we,
    output logic          data_re,
    input  rv_pkg::word_t read_data
);
    import rv_pkg::*;

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    wb_t      wb;
    reg_idx_t rs1_d;
    reg_idx_t rs2_d;
    logic     branch_taken;
    word_t    branch_target;
    logic     stall_f;
    logic     stall_d;
    logic     flush_d;
    logic     flush_e;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    fetch_stage #(.reset_pc(reset_pc)) u_fetch (
        .clk(clk),
        .rst(rst),
        .stall_f(stall_f),
        .stall_d(stall_d),
        .flush_d(flush_d),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .instr(instr),
        .pc(pc),
        .if_id(if_id)
    );

    decode_stage u_decode (
        .clk(clk),
        .rst(rst),
        .if_id(if_id),
        .flush_e(flush_e),
        .wb(wb),
        .id_ex(id_ex),
        .rs1_d(rs1_d),
        .rs2_d(rs2_d)
    );

    execute_stage u_execute (
        .clk(clk),
        .rst(rst),
        .id_ex(id_ex),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .ex_mem(ex_mem),
        .wb(wb),
        .data_addr(data_addr),
        .din(din),
        .data_we(data_we),
        .data_re(data_re),
        .branch_taken(branch_taken),
        .branch_target(branch_target)
    );

    mem_wb_stage u_mem_wb (
        .clk(clk),
        .rst(rst),
        .ex_mem(ex_mem),
        .read_data(read_data),
        .wb(wb)
    );

    hazard_unit u_hazard (
        .rs1_d(rs1_d),
        .rs2_d(rs2_d),
        .id_ex(id_ex),
        .ex_mem(ex_mem),
        .wb(wb),
        .branch_taken(branch_taken),
        .stall_f(stall_f),
        .stall_d(stall_d),
        .flush_d(flush_d),
        .flush_e(flush_e),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b)
    );

endmodule

//--- verif/riscv_pipeline_asserts.sv
module riscv_pipeline_asserts (
    input logic          clk,
    input logic          rst,
    input rv_pkg::word_t pc,
    input logic          data_we,
    input logic          data_re,
    input logic          stall_f,
    input logic          branch_taken
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // one data access per cycle
    property p_mem_exclusive;
        @(posedge clk) disable iff (rst) !(data_we && data_re);
    endproperty

    property p_pc_aligned;
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00;
    endproperty

    // pc frozen by a load-use stall
    property p_pc_hold;
        @(posedge clk) disable iff (rst) (stall_f && !branch_taken) |=> $stable(pc);
    endproperty

    a_mem_exclusive: assert property (p_mem_exclusive)
        else begin
            $error("data_we and data_re high together");
            fail_count++;
        end
    a_pc_aligned: assert property (p_pc_aligned)
        else begin
            $error("pc not word aligned: %h", pc);
            fail_count++;
        end
    a_pc_hold: assert property (p_pc_hold)
        else begin
            $error("pc moved during fetch stall");
            fail_count++;
        end

endmodule

bind riscv_pipeline riscv_pipeline_asserts u_asserts (
    .clk(clk),
    .rst(rst),
    .pc(pc),
    .data_we(data_we),
    .data_re(data_re),
    .stall_f(stall_f),
    .branch_taken(branch_taken)
);

//--- verif/tb_riscv_pipeline.sv
module tb_riscv_pipeline;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam word_t reset_pc = '0;
    localparam int num_progs = 8;
    localparam int body_len = 32;
    localparam int halt_idx = 39;
    localparam int prog_len = 40;
    // programs times a bound on cycles per program
    localparam int max_cycles = num_progs * (47 * 3 + 20);
    localparam word_t nop = 32'h0000_0013;

    localparam int k_add = 0;
    localparam int k_sub = 1;
    localparam int k_and = 2;
    localparam int k_or = 3;
    localparam int k_xor = 4;
    localparam int k_slt = 5;
    localparam int k_addi = 6;
    localparam int k_lw = 7;
    localparam int k_sw = 8;
    localparam int k_beq = 9;

    logic  clk;
    logic  rst;
    word_t pc;
    word_t instr;
    word_t data_addr;
    word_t din;
    logic  data_we;
    logic  data_re;
    word_t read_data;

    word_t imem [64];
    word_t dmem [64];
    word_t model_mem [64];
    int    p_kind [prog_len];
    int    p_rd [prog_len];
    int    p_rs1 [prog_len];
    int    p_rs2 [prog_len];
    int    p_imm [prog_len];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    st_idx = 0;
    int    cycles = 0;
    logic [31:0] lfsr = 32'd56;

    riscv_pipeline #(.reset_pc(reset_pc)) UUT (
        .clk(clk),
        .rst(rst),
        .pc(pc),
        .instr(instr),
        .data_addr(data_addr),
        .din(din),
        .data_we(data_we),
        .data_re(data_re),
        .read_data(read_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_fail();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
            stop_fail();
        end
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t fill_word(input int addr, input int n);
        return (word_t'(addr) * 32'h9e37_79b1) ^ (word_t'(n) << 24) ^ 32'h0000_5a3c;
    endfunction

    function automatic word_t encode(input int i);
        word_t      im;
        logic [4:0] d;
        logic [4:0] s1;
        logic [4:0] s2;
        im = word_t'(p_imm[i]);
        d  = 5'(p_rd[i]);
        s1 = 5'(p_rs1[i]);
        s2 = 5'(p_rs2[i]);
        case (p_kind[i])
            k_add:  return {7'h00, s2, s1, 3'b000, d, 7'h33};
            k_sub:  return {7'h20, s2, s1, 3'b000, d, 7'h33};
            k_and:  return {7'h00, s2, s1, 3'b111, d, 7'h33};
            k_or:   return {7'h00, s2, s1, 3'b110, d, 7'h33};
            k_xor:  return {7'h00, s2, s1, 3'b100, d, 7'h33};
            k_slt:  return {7'h00, s2, s1, 3'b010, d, 7'h33};
            k_addi: return {im[11:0], s1, 3'b000, d, 7'h13};
            k_lw:   return {im[11:0], s1, 3'b010, d, 7'h03};
            k_sw:   return {im[11:5], s2, s1, 3'b010, im[4:0], 7'h23};
            default: return {im[12], im[10:5], s2, s1, 3'b000, im[4:1], im[11], 7'h63};
        endcase
    endfunction

    task automatic gen_program();
        logic [31:0] sel;
        logic [31:0] b;
        int prev_rd;
        prev_rd = 0;
        for (int i = 0; i < body_len; i++) begin
            sel      = rand_bits(4);
            p_rd[i]  = rand_bits(3);
            p_rs1[i] = rand_bits(3);
            p_rs2[i] = rand_bits(3);
            p_imm[i] = 0;
            // lean on the previous result to stress forwarding
            if (rand_bits(1) == 1) begin
                p_rs1[i] = prev_rd;
            end
            if (sel < 6) begin
                p_kind[i] = sel;
            end else if (sel < 9 || sel == 15) begin
                p_kind[i] = k_addi;
                b = rand_bits(12);
                p_imm[i] = {{20{b[11]}}, b[11:0]};
            end else if (sel < 13) begin
                p_kind[i] = (sel < 11) ? k_lw : k_sw;
                p_rs1[i] = 0;
                p_imm[i] = rand_bits(6) * 4;
            end else if (i == body_len - 1) begin
                p_kind[i] = k_add;
            end else begin
                // target never lands past the final stores
                p_kind[i] = k_beq;
                p_imm[i] = (rand_bits(1) == 1) ? 12 : 8;
                if (i + p_imm[i] / 4 > body_len) begin
                    p_imm[i] = 8;
                end
                if (rand_bits(1) == 1) begin
                    p_rs2[i] = p_rs1[i];
                end
            end
            prev_rd = p_rd[i];
        end
        for (int k = 1; k <= 7; k++) begin
            p_kind[body_len + k - 1] = k_sw;
            p_rd[body_len + k - 1]   = 0;
            p_rs1[body_len + k - 1]  = 0;
            p_rs2[body_len + k - 1]  = k;
            p_imm[body_len + k - 1]  = 224 + 4 * (k - 1);
        end
        p_kind[halt_idx] = k_beq;
        p_rd[halt_idx]   = 0;
        p_rs1[halt_idx]  = 0;
        p_rs2[halt_idx]  = 0;
        p_imm[halt_idx]  = 0;
    endtask

    task automatic load_memories(input int n);
        for (int k = 0; k < 64; k++) begin
            imem[k]      = (k < prog_len) ? encode(k) : nop;
            dmem[k]      = fill_word(k * 4, n);
            model_mem[k] = fill_word(k * 4, n);
        end
    endtask

    // ISA level interpreter
    task automatic run_model();
        word_t regs [8];
        word_t a;
        word_t b;
        word_t r;
        logic  wr;
        int    i;
        for (int k = 0; k < 8; k++) begin
            regs[k] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        i = 0;
        while (i != halt_idx) begin
            a  = regs[p_rs1[i]];
            b  = regs[p_rs2[i]];
            r  = '0;
            wr = 1'b1;
            case (p_kind[i])
                k_add:  r = a + b;
                k_sub:  r = a - b;
                k_and:  r = a & b;
                k_or:   r = a | b;
                k_xor:  r = a ^ b;
                k_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                k_addi: r = a + word_t'(p_imm[i]);
                k_lw:   r = model_mem[p_imm[i] / 4];
                k_sw: begin
                    wr = 1'b0;
                    model_mem[p_imm[i] / 4] = b;
                    exp_addr.push_back(word_t'(p_imm[i]));
                    exp_data.push_back(b);
                end
                default: wr = 1'b0;
            endcase
            if (wr && p_rd[i] != 0) begin
                regs[p_rd[i]] = r;
            end
            if (p_kind[i] == k_beq && a == b) begin
                i = i + p_imm[i] / 4;
            end else begin
                i = i + 1;
            end
        end
    endtask

    task automatic run_program(input int n);
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        gen_program();
        load_memories(n);
        run_model();
        st_idx = 0;
        repeat (6) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_eq("pc", pc, reset_pc);
        check_eq("data_we", word_t'(data_we), '0);
        check_eq("data_re", word_t'(data_re), '0);
        while (pc !== reset_pc + word_t'(halt_idx * 4)) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);
        if (st_idx != exp_addr.size()) begin
            $display("program %0d: saw %0d stores but expected %0d before the halt",
                     n, st_idx, exp_addr.size());
            stop_fail();
        end
    endtask

    assign instr = imem[pc[7:2]];

    // synchronous-read data memory
    always @(posedge clk) begin
        if (data_we === 1'b1) begin
            dmem[data_addr[7:2]] <= din;
        end
        if (data_re === 1'b1) begin
            read_data <= dmem[data_addr[7:2]];
        end
    end

    always @(negedge clk) begin
        if (!rst && data_we === 1'b1) begin
            if (st_idx >= exp_addr.size()) begin
                $display("a store to 0x%08h appeared that the program does not make",
                         data_addr);
                stop_fail();
            end else begin
                check_eq("data_addr", data_addr, exp_addr[st_idx]);
                check_eq("din", din, exp_data[st_idx]);
                st_idx = st_idx + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (UUT.u_asserts.fail_count != 0) begin
            $display("a concurrent assertion on the DUT failed");
            stop_fail();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("run did not finish within %0d cycles", max_cycles);
            stop_fail();
        end
    end

    initial begin
        rst <= 1'b1;
        read_data <= '0;
        for (int k = 0; k < 64; k++) begin
            imem[k] = nop;
            dmem[k] = fill_word(k * 4, 0);
        end
        for (int n = 0; n < num_progs; n++) begin
            run_program(n);
        end
        if (UUT.u_asserts.fail_count != 0) begin
            $display("a concurrent assertion on the DUT failed");
            stop_fail();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- src.f
common/rv_pkg.sv
rtl/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
rtl/execute_stage.sv
rtl/hazard_unit.sv
rtl/mem_wb_stage.sv
rtl/riscv_pipeline.sv
verif/riscv_pipeline_asserts.sv
verif/tb_riscv_pipeline.sv
